// File: Makefile
# Verilator simulation of the execute stage

TOP := tb_execute_top

.PHONY: help test clean

help:
	@echo "make help   list these targets"
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f execute_stage.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log || (echo "No pass result in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: execute_stage.f
verilog/exec_pkg.sv
verilog/exec_alu.sv
verilog/eflags_reg.sv
verilog/pipestage.sv
verilog/execute_top.sv
testbench/tb_execute_top.sv

// File: testbench/tb_execute_top.sv
// ------------------------------------------------------------------------
// Execute stage testbench
// Reference model, random traffic with stalls and flushes, in-order checks
// ------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_execute_top;

    localparam int n_sweep    = 120;
    localparam int n_random   = 300;
    localparam int n_flush    = 5;
    localparam int max_cycles = 4 * (n_sweep + n_random + 5 * n_flush) + 200;

    logic                clk;
    logic                rst_n;
    logic                flush;
    logic                e_valid;
    logic                e_ready;
    logic                wb_ready;
    logic                wb_valid;
    exec_pkg::exec_req_t e_req;
    exec_pkg::wb_pkt_t   wb_pkt;
    exec_pkg::eflags_t   flags;
    exec_pkg::eflags_t   model_flags;
    exec_pkg::wb_pkt_t   exp_q[$];
    int                  seed;
    int                  errors;
    int                  checked;
    int                  cycles;
    int                  ready_mode;

    execute_top dut (.*);

    always #50 clk = ~clk;

    task automatic check_word(input string name, input exec_pkg::word_t got,
                              input exec_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flags(input string name, input exec_pkg::eflags_t got,
                               input exec_pkg::eflags_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    // Expected writeback packet and next flags for one request
    function automatic exec_pkg::wb_pkt_t compute_expected(input exec_pkg::exec_req_t r,
            input exec_pkg::eflags_t f, output exec_pkg::eflags_t f_next);
        exec_pkg::wb_pkt_t p;
        exec_pkg::word_t   m;
        exec_pkg::word_t   a;
        exec_pkg::word_t   b;
        exec_pkg::word_t   res;
        logic [63:0]       full;
        int                n;
        logic              cf;
        logic              of_f;
        logic              upd;
        logic              taken;
        logic              jmp;
        n = (r.opsize == 2'd0) ? 8 : (r.opsize == 2'd1) ? 16 : 32;
        m = (n == 32) ? 32'hffff_ffff : ((32'd1 << n) - 32'd1);
        a = r.op_a & m;
        b = r.op_b & m;
        res = '0;
        cf = 1'b0;
        of_f = 1'b0;
        upd = 1'b1;
        taken = 1'b0;
        jmp = 1'b0;
        case (r.op)
            exec_pkg::op_add: begin
                full = {32'b0, a} + {32'b0, b};
                res = full[31:0] & m;
                cf = full[n];
                of_f = (a[n-1] == b[n-1]) && (res[n-1] != a[n-1]);
            end
            exec_pkg::op_sub: begin
                res = (a - b) & m;
                cf = (a < b);
                of_f = (a[n-1] != b[n-1]) && (res[n-1] != a[n-1]);
            end
            exec_pkg::op_and: res = a & b;
            exec_pkg::op_or:  res = a | b;
            exec_pkg::op_xor: res = a ^ b;
            exec_pkg::op_shl: begin
                full = {32'b0, a} << r.op_b[4:0];
                res = full[31:0] & m;
                cf = full[n];
                of_f = res[n-1] ^ cf;
            end
            exec_pkg::op_shr: begin
                res = a >> r.op_b[4:0];
                if (r.op_b[4:0] != 5'd0)
                    cf = a[int'(r.op_b[4:0]) - 1];
                of_f = a[n-1];
            end
            exec_pkg::op_mov: begin
                res = b;
                upd = 1'b0;
            end
            exec_pkg::op_jmp: begin
                jmp = 1'b1;
                taken = 1'b1;
                upd = 1'b0;
            end
            exec_pkg::op_jz: begin
                jmp = 1'b1;
                taken = f.zf;
                upd = 1'b0;
            end
            default: upd = 1'b0;
        endcase
        f_next = f;
        if (upd) begin
            f_next.cf = cf;
            f_next.of_f = of_f;
            f_next.sf = res[n-1];
            f_next.zf = (res == '0);
        end
        if (r.set_df)
            f_next.df = 1'b1;
        else if (r.clear_df)
            f_next.df = 1'b0;
        p.result = res;
        p.dest_reg = r.dest_reg;
        p.opsize = r.opsize;
        p.pc = r.pc;
        p.jump_load = taken;
        p.jump_address = r.op_b;
        p.br_mispredict = jmp && (taken != r.pred_taken);
        return p;
    endfunction

    function automatic exec_pkg::exec_req_t random_req(input logic [3:0] op,
                                                       input exec_pkg::opsize_t sz);
        exec_pkg::exec_req_t r;
        exec_pkg::word_t     w;
        w = $random(seed);
        r.op_a = $random(seed);
        // Equal operands now and then, to reach a zero result
        r.op_b = (w[12:10] == 3'b000) ? r.op_a : $random(seed);
        r.op = exec_pkg::alu_op_t'(op);
        r.opsize = sz;
        r.dest_reg = w[9:7];
        r.set_df = (w[3:1] == 3'b000);
        r.clear_df = !r.set_df && (w[6:4] == 3'b000);
        r.pred_taken = w[0];
        r.pc = {w[31:2], 2'b00};
        return r;
    endfunction

    // 0 always ready, 1 random stalls, 2 never ready
    function automatic logic pick_ready();
        exec_pkg::word_t w;
        w = $random(seed);
        case (ready_mode)
            0:       return 1'b1;
            1:       return w[1:0] != 2'b00;
            default: return 1'b0;
        endcase
    endfunction

    // Hold the request until the stage takes it
    task automatic send(input exec_pkg::exec_req_t r);
        logic done;
        done = 1'b0;
        while (!done) begin
            e_req = r;
            e_valid = 1'b1;
            wb_ready = pick_ready();
            @(negedge clk);
            done = e_ready;
            @(posedge clk);
            #1;
        end
        e_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            wb_ready = 1'b1;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic flush_episode();
        drain();
        ready_mode = 2;
        send(random_req(4'(exec_pkg::op_add), 2'd2));
        // Held packet and a fresh request both die in the flush
        flush = 1'b1;
        e_valid = 1'b1;
        e_req = random_req(4'(exec_pkg::op_sub), 2'd0);
        @(posedge clk);
        #1;
        flush = 1'b0;
        e_valid = 1'b0;
        @(negedge clk);
        #1;
        check_bit("wb_valid", wb_valid, 1'b0);
        if (exp_q.size() != 0) begin
            errors++;
            $display("Error: expected packets still pending after a flush");
        end
        @(posedge clk);
        #1;
        ready_mode = 1;
    endtask

    // Model update and checks on the falling edge
    always @(negedge clk) begin
        exec_pkg::wb_pkt_t exp_pkt;
        exec_pkg::eflags_t next_flags;
        logic              exp_valid;
        logic              exp_ready;
        if (rst_n) begin
            // The single entry is full exactly while the model has a packet queued
            exp_valid = (exp_q.size() != 0);
            exp_ready = !flush && (!exp_valid || wb_ready);
            check_bit("wb_valid", wb_valid, exp_valid);
            check_bit("e_ready", e_ready, exp_ready);
            check_flags("flags", flags, model_flags);
            if (wb_valid && flush) begin
                if (exp_q.size() != 0)
                    void'(exp_q.pop_front());
                else begin
                    errors++;
                    $display("Error: flush hit a packet that was never accepted");
                end
            end else if (wb_valid && wb_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Error: packet left writeback with none expected");
                end else begin
                    exp_pkt = exp_q.pop_front();
                    checked++;
                    check_word("wb_pkt.result", wb_pkt.result, exp_pkt.result);
                    check_word("wb_pkt.dest_reg", 32'(wb_pkt.dest_reg), 32'(exp_pkt.dest_reg));
                    check_word("wb_pkt.opsize", 32'(wb_pkt.opsize), 32'(exp_pkt.opsize));
                    check_word("wb_pkt.pc", wb_pkt.pc, exp_pkt.pc);
                    check_word("wb_pkt.jump_address", wb_pkt.jump_address,
                               exp_pkt.jump_address);
                    check_bit("wb_pkt.jump_load", wb_pkt.jump_load, exp_pkt.jump_load);
                    check_bit("wb_pkt.br_mispredict", wb_pkt.br_mispredict,
                              exp_pkt.br_mispredict);
                end
            end
            if (e_valid && exp_ready) begin
                exp_pkt = compute_expected(e_req, model_flags, next_flags);
                exp_q.push_back(exp_pkt);
                model_flags = next_flags;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("Error: run did not finish within %0d cycles", max_cycles);
            $display("Errors: %0d, packets checked: %0d", errors, checked);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        seed = 32'hee6b;
        clk = 1'b0;
        rst_n = 1'b0;
        flush = 1'b0;
        e_valid = 1'b0;
        e_req = '0;
        wb_ready = 1'b0;
        errors = 0;
        checked = 0;
        cycles = 0;
        ready_mode = 0;
        model_flags = exec_pkg::eflags_reset;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("e_ready", e_ready, 1'b1);
        check_bit("wb_valid", wb_valid, 1'b0);
        @(posedge clk);
        #1;
        // Every operation at every size, back to back
        for (int op = 0; op < 10; op++)
            for (int sz = 0; sz < 4; sz++)
                repeat (3) send(random_req(4'(op), 2'(sz)));
        ready_mode = 1;
        repeat (n_random)
            send(random_req(4'($unsigned($random(seed)) % 10), 2'($random(seed))));
        repeat (n_flush) begin
            flush_episode();
            repeat (3)
                send(random_req(4'($unsigned($random(seed)) % 10), 2'($random(seed))));
        end
        drain();
        $display("Errors: %0d, packets checked: %0d", errors, checked);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: verilog/eflags_reg.sv
// ------------------------------------------------------------------------
// Architectural flags register
// Masked update of CF/ZF/SF/OF, DF set and clear on accepted requests
// ------------------------------------------------------------------------
`timescale 1ns/1ps

module eflags_reg (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 update,
    input  exec_pkg::eflags_t    flags_new,
    input  exec_pkg::flag_mask_t flags_mask,
    input  logic                 set_df,
    input  logic                 clear_df,
    output exec_pkg::eflags_t    flags
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= exec_pkg::eflags_reset;
        end else if (update) begin
            if (flags_mask[exec_pkg::mask_cf])
                flags.cf <= flags_new.cf;
            if (flags_mask[exec_pkg::mask_zf])
                flags.zf <= flags_new.zf;
            if (flags_mask[exec_pkg::mask_sf])
                flags.sf <= flags_new.sf;
            if (flags_mask[exec_pkg::mask_of])
                flags.of_f <= flags_new.of_f;

            // Set has priority over clear
            if (set_df)
                flags.df <= 1'b1;
            else if (clear_df)
                flags.df <= 1'b0;
        end
    end

    // Decode never asks for both DF edits in one instruction
    a_df_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        update |-> !(set_df && clear_df)
    ) else $error("eflags_reg: set_df and clear_df both high on update");

endmodule

// File: verilog/exec_alu.sv
// ------------------------------------------------------------------------
// Execute ALU
// Sized integer operations with CF/ZF/SF/OF generation and
// resolution of the unconditional and zero-flag jumps
// ------------------------------------------------------------------------
`timescale 1ns/1ps

module exec_alu (
    input  exec_pkg::exec_req_t  req,
    input  exec_pkg::eflags_t    flags_in,
    output exec_pkg::word_t      result,
    output exec_pkg::eflags_t    flags_out,
    output exec_pkg::flag_mask_t flags_mask,
    output logic                 jump_load,
    output exec_pkg::word_t      jump_address,
    output logic                 br_mispredict
);

    function automatic exec_pkg::word_t size_mask(input exec_pkg::opsize_t sz);
        case (sz)
            2'd0:    return 32'h0000_00ff;
            2'd1:    return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    // Sign bit of an operand of the given size
    function automatic logic sign_of(input exec_pkg::word_t w, input exec_pkg::opsize_t sz);
        case (sz)
            2'd0:    return w[7];
            2'd1:    return w[15];
            default: return w[31];
        endcase
    endfunction

    // Bit just above the operand, carry or borrow out
    function automatic logic carry_of(input logic [63:0] w, input exec_pkg::opsize_t sz);
        case (sz)
            2'd0:    return w[8];
            2'd1:    return w[16];
            default: return w[32];
        endcase
    endfunction

    exec_pkg::word_t mask;
    exec_pkg::word_t a_m;
    exec_pkg::word_t b_m;
    exec_pkg::word_t res_raw;
    logic [4:0]      shamt;
    logic [32:0]     sum;
    logic [32:0]     diff;
    logic [63:0]     shl_wide;
    logic [32:0]     shr_wide;
    logic            sa;
    logic            sb;
    logic            cf_n;
    logic            of_n;
    logic            is_jump;

    always_comb begin
        mask     = size_mask(req.opsize);
        a_m      = req.op_a & mask;
        b_m      = req.op_b & mask;
        shamt    = req.op_b[4:0];
        sum      = {1'b0, a_m} + {1'b0, b_m};
        diff     = {1'b0, a_m} - {1'b0, b_m};
        shl_wide = {32'b0, a_m} << shamt;
        // Extra low bit catches the last bit shifted out
        shr_wide = {a_m, 1'b0} >> shamt;
        sa       = sign_of(a_m, req.opsize);
        sb       = sign_of(b_m, req.opsize);

        res_raw    = '0;
        cf_n       = 1'b0;
        of_n       = 1'b0;
        flags_mask = exec_pkg::mask_none;
        jump_load  = 1'b0;
        is_jump    = 1'b0;

        case (req.op)
            exec_pkg::op_add: begin
                res_raw    = sum[31:0];
                cf_n       = carry_of({31'b0, sum}, req.opsize);
                of_n       = (sa == sb) && (sign_of(sum[31:0], req.opsize) != sa);
                flags_mask = exec_pkg::mask_all;
            end
            exec_pkg::op_sub: begin
                res_raw    = diff[31:0];
                cf_n       = carry_of({31'b0, diff}, req.opsize);
                of_n       = (sa != sb) && (sign_of(diff[31:0], req.opsize) != sa);
                flags_mask = exec_pkg::mask_all;
            end
            // Logic ops write CF and OF as zero
            exec_pkg::op_and: begin
                res_raw    = a_m & b_m;
                flags_mask = exec_pkg::mask_all;
            end
            exec_pkg::op_or: begin
                res_raw    = a_m | b_m;
                flags_mask = exec_pkg::mask_all;
            end
            exec_pkg::op_xor: begin
                res_raw    = a_m ^ b_m;
                flags_mask = exec_pkg::mask_all;
            end
            exec_pkg::op_shl: begin
                res_raw    = shl_wide[31:0];
                cf_n       = carry_of(shl_wide, req.opsize);
                of_n       = sign_of(shl_wide[31:0] & mask, req.opsize) ^ cf_n;
                flags_mask = exec_pkg::mask_all;
            end
            exec_pkg::op_shr: begin
                res_raw    = shr_wide[32:1];
                cf_n       = shr_wide[0];
                of_n       = sa;
                flags_mask = exec_pkg::mask_all;
            end
            exec_pkg::op_mov: res_raw = b_m;
            exec_pkg::op_jmp: begin
                is_jump   = 1'b1;
                jump_load = 1'b1;
            end
            exec_pkg::op_jz: begin
                is_jump   = 1'b1;
                jump_load = flags_in.zf;
            end
            default: res_raw = '0;
        endcase

        result         = res_raw & mask;
        flags_out.df   = flags_in.df;
        flags_out.of_f = of_n;
        flags_out.sf   = sign_of(result, req.opsize);
        flags_out.zf   = (result == '0);
        flags_out.cf   = cf_n;
        jump_address   = req.op_b;
        br_mispredict  = is_jump && (jump_load != req.pred_taken);
    end

    // Decode must never hand over one of the unused op codes
    always_comb begin
        assert (req.op <= exec_pkg::op_jz)
            else $error("exec_alu: illegal operation code %0h", req.op);
    end

endmodule

// File: verilog/exec_pkg.sv
// ------------------------------------------------------------------------
// Execute stage shared definitions
// Widths, ALU operation codes, flag layout and the request and
// writeback packets passed between decode, execute and writeback
// ------------------------------------------------------------------------

package exec_pkg;

    localparam int word_w    = 32;
    localparam int reg_idx_w = 3;

    typedef logic [word_w-1:0]    word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // 0 = 8 bit, 1 = 16 bit, 2 = 32 bit, 3 is reserved and treated as 32
    typedef logic [1:0] opsize_t;

    // Per-flag write enables for the arithmetic flags
    typedef logic [3:0] flag_mask_t;

    localparam int mask_cf = 0;
    localparam int mask_zf = 1;
    localparam int mask_sf = 2;
    localparam int mask_of = 3;

    localparam flag_mask_t mask_all  = 4'b1111;
    localparam flag_mask_t mask_none = 4'b0000;

    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_shl = 4'd5,
        op_shr = 4'd6,
        op_mov = 4'd7,
        op_jmp = 4'd8,
        op_jz  = 4'd9
    } alu_op_t;

    typedef struct packed {
        logic df;
        logic of_f;
        logic sf;
        logic zf;
        logic cf;
    } eflags_t;

    localparam eflags_t eflags_reset = '0;

    typedef struct packed {
        word_t    op_a;
        word_t    op_b;
        alu_op_t  op;
        opsize_t  opsize;
        reg_idx_t dest_reg;
        logic     set_df;
        logic     clear_df;
        logic     pred_taken;
        word_t    pc;
    } exec_req_t;

    typedef struct packed {
        word_t    result;
        reg_idx_t dest_reg;
        opsize_t  opsize;
        word_t    pc;
        logic     jump_load;
        word_t    jump_address;
        logic     br_mispredict;
    } wb_pkt_t;

endpackage

// File: verilog/execute_top.sv
// ------------------------------------------------------------------------
// Execute stage top
// ALU and flags register feed a one-entry slice toward writeback
// ------------------------------------------------------------------------
`timescale 1ns/1ps

module execute_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                e_valid,
    output logic                e_ready,
    input  exec_pkg::exec_req_t e_req,
    input  logic                wb_ready,
    output logic                wb_valid,
    output exec_pkg::wb_pkt_t   wb_pkt,
    output exec_pkg::eflags_t   flags
);

    exec_pkg::word_t      alu_result;
    exec_pkg::eflags_t    alu_flags;
    exec_pkg::flag_mask_t alu_mask;
    logic                 alu_jump_load;
    exec_pkg::word_t      alu_jump_address;
    logic                 alu_mispredict;
    logic                 stage_valid;
    logic                 accept;
    exec_pkg::wb_pkt_t    stage_pkt;

    exec_alu u_alu (
        .req           (e_req),
        .flags_in      (flags),
        .result        (alu_result),
        .flags_out     (alu_flags),
        .flags_mask    (alu_mask),
        .jump_load     (alu_jump_load),
        .jump_address  (alu_jump_address),
        .br_mispredict (alu_mispredict)
    );

    // Nothing is taken in while a flush is in progress
    assign stage_valid = e_valid && !flush;
    assign accept      = stage_valid && e_ready;

    eflags_reg u_eflags (
        .clk        (clk),
        .rst_n      (rst_n),
        .update     (accept),
        .flags_new  (alu_flags),
        .flags_mask (alu_mask),
        .set_df     (e_req.set_df),
        .clear_df   (e_req.clear_df),
        .flags      (flags)
    );

    always_comb begin
        stage_pkt.result        = alu_result;
        stage_pkt.dest_reg      = e_req.dest_reg;
        stage_pkt.opsize        = e_req.opsize;
        stage_pkt.pc            = e_req.pc;
        stage_pkt.jump_load     = alu_jump_load;
        stage_pkt.jump_address  = alu_jump_address;
        stage_pkt.br_mispredict = alu_mispredict;
    end

    pipestage u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (stage_valid),
        .in_ready  (e_ready),
        .in_pkt    (stage_pkt),
        .out_valid (wb_valid),
        .out_ready (wb_ready),
        .out_pkt   (wb_pkt)
    );

endmodule

// File: verilog/pipestage.sv
// ------------------------------------------------------------------------
// Execute to writeback pipeline register
// One-entry valid/ready slice with flush, holds the writeback packet
// ------------------------------------------------------------------------
`timescale 1ns/1ps

module pipestage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              in_valid,
    output logic              in_ready,
    input  exec_pkg::wb_pkt_t in_pkt,
    output logic              out_valid,
    input  logic              out_ready,
    output exec_pkg::wb_pkt_t out_pkt
);

    logic load;

    // Room when empty or when the held packet leaves this cycle
    assign in_ready = !flush && (!out_valid || out_ready);
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load)
            out_pkt <= in_pkt;
    end

    // Stalled packet must not change under writeback
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> $stable(out_pkt)
    ) else $error("pipestage: packet changed while stalled");

endmodule
